// File: run_sim.sh
#!/bin/sh
# build and run the ADC fiber link testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_adc_fiber_link -f tb.f -o tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi

// File: tb.f
+incdir+include
verilog/adc_link_pkg.sv
verilog/adc_capture.sv
verilog/frame_tagger.sv
verilog/link_credit_fifo.sv
verilog/adc_fiber_link_top.sv
test/tb_adc_fiber_link.sv

// File: include/adc_link_tb_ref.svh
`ifndef ADC_LINK_TB_REF_SVH
`define ADC_LINK_TB_REF_SVH

// expected conversion of one raw code
function automatic adc_link_pkg::adc_sample_t ref_convert(
    input adc_link_pkg::adc_code_t code
);
    ref_convert = code ^ (adc_link_pkg::adc_code_t'(1) << (adc_link_pkg::ADC_W - 1));
endfunction

// expected link word for sample number n, codes taken from the stimulus log
function automatic adc_link_pkg::link_word_t ref_word(
    input int unsigned             n,
    input adc_link_pkg::adc_code_t code_a,
    input adc_link_pkg::adc_code_t code_b
);
    adc_link_pkg::link_word_t w;
    w.ch_b      = ref_convert(code_b);
    w.ch_a      = ref_convert(code_a);
    w.frame_idx = adc_link_pkg::frame_idx_t'(n % adc_link_pkg::FRAME_LEN);
    w.frame_num = adc_link_pkg::frame_num_t'((n / adc_link_pkg::FRAME_LEN) % 16);
    ref_word    = w;
endfunction

// frame fields of a received word give the sample number modulo 256
function automatic int unsigned ref_seq_mod256(input adc_link_pkg::link_word_t w);
    ref_seq_mod256 = {24'd0, w.frame_num, w.frame_idx};
endfunction

`endif

// File: test/tb_adc_fiber_link.sv
`timescale 1ns/1ps
`default_nettype none

module tb_adc_fiber_link;

    `include "adc_link_tb_ref.svh"

    logic                     clk_29_7_1M = 1'b0;
    logic                     rst = 1'b0;
    logic                     i_adc_valid = 1'b0;
    adc_link_pkg::adc_code_t  i_adc_a = '0;
    adc_link_pkg::adc_code_t  i_adc_b = '0;
    logic                     i_credit_return = 1'b0;
    logic                     o_link_valid;
    adc_link_pkg::link_word_t o_link_word;
    adc_link_pkg::drop_cnt_t  o_drop_count;

    integer seed;
    int     err_count = 0;    // value mismatches
    int     fail_count = 0;   // timeouts and stream faults
    int     rx_count = 0;     // link words since the last reset
    logic   credit_en = 1'b1; // receiver hands credits back

    adc_link_pkg::adc_code_t log_a[$];  // codes of accepted input cycles
    adc_link_pkg::adc_code_t log_b[$];

    adc_fiber_link_top adc_fiber_link_top_inst (
        .clk_29_7_1M     (clk_29_7_1M),
        .rst             (rst),
        .i_adc_valid     (i_adc_valid),
        .i_adc_a         (i_adc_a),
        .i_adc_b         (i_adc_b),
        .i_credit_return (i_credit_return),
        .o_link_valid    (o_link_valid),
        .o_link_word     (o_link_word),
        .o_drop_count    (o_drop_count)
    );

    initial begin
        forever begin
            #2 clk_29_7_1M = ~clk_29_7_1M;  // 4 ns period
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
            err_count++;
        end
    endtask

    // receiver model samples the outputs at the falling edge where they are stable
    always @(negedge clk_29_7_1M) begin : compare_blk
        static int owed = 0;          // credits spent and not yet returned
        static int exp_n = 0;         // next expected sample number
        static int dropped_seen = 0;
        adc_link_pkg::link_word_t got;
        adc_link_pkg::link_word_t exp_w;
        int seq;
        int gap;
        if (!rst) begin
            owed = 0;
            exp_n = 0;
            dropped_seen = 0;
            rx_count <= 0;
            i_credit_return <= 1'b0;
        end else begin
            if (o_link_valid) begin
                got = o_link_word;
                seq = int'(ref_seq_mod256(got));
                gap = 0;
                while ((exp_n % 256) != seq && gap < 256) begin
                    exp_n++;
                    gap++;
                end
                dropped_seen += gap;
                if (dropped_seen > int'(o_drop_count)) begin
                    $display("stream skipped %0d samples but only %0d drops were counted",
                             dropped_seen, o_drop_count);
                    fail_count++;
                end
                if (exp_n >= log_a.size()) begin
                    $display("link word for sample %0d which was never driven", exp_n);
                    fail_count++;
                end else begin
                    exp_w = ref_word(exp_n, log_a[exp_n], log_b[exp_n]);
                    check_value("o_link_word.ch_a", 32'(exp_w.ch_a), 32'(got.ch_a));
                    check_value("o_link_word.ch_b", 32'(exp_w.ch_b), 32'(got.ch_b));
                    check_value("o_link_word.frame_num", 32'(exp_w.frame_num),
                                32'(got.frame_num));
                    check_value("o_link_word.frame_idx", 32'(exp_w.frame_idx),
                                32'(got.frame_idx));
                end
                exp_n++;
                owed++;
                rx_count <= rx_count + 1;
            end
            if (credit_en && owed > 0) begin
                i_credit_return <= 1'b1;
                owed--;
            end else begin
                i_credit_return <= 1'b0;
            end
        end
    end

    task automatic do_reset();
        @(negedge clk_29_7_1M);
        rst <= 1'b0;
        i_adc_valid <= 1'b0;
        @(negedge clk_29_7_1M);
        // the first reset edge clears both
        check_value("o_link_valid", 32'(0), 32'(o_link_valid));
        check_value("o_drop_count", 32'(0), 32'(o_drop_count));
        repeat (15) @(negedge clk_29_7_1M);
        log_a.delete();  // sample numbers restart at 0
        log_b.delete();
        rst <= 1'b1;
    endtask

    // drives count accepted samples with optional random idle cycles
    task automatic drive_samples(input int count, input bit gaps, input int limit);
        logic [31:0] r;
        int sent;
        int cycles;
        sent = 0;
        cycles = 0;
        while (sent < count && cycles < limit) begin
            @(negedge clk_29_7_1M);
            cycles++;
            r = $random(seed);
            i_adc_a <= r[11:0];
            i_adc_b <= r[23:12];
            if (!gaps || r[31:30] != 2'b00) begin
                i_adc_valid <= 1'b1;
                log_a.push_back(r[11:0]);
                log_b.push_back(r[23:12]);
                sent++;
            end else begin
                i_adc_valid <= 1'b0;
            end
        end
        @(negedge clk_29_7_1M);
        i_adc_valid <= 1'b0;
        if (sent < count) begin
            $display("timeout: drove only %0d of %0d samples", sent, count);
            fail_count++;
        end
    endtask

    task automatic wait_rx(input int target, input int limit);
        int cycles;
        cycles = 0;
        while (rx_count < target && cycles < limit) begin
            @(negedge clk_29_7_1M);
            cycles++;
        end
        if (rx_count < target) begin
            $display("timeout: only %0d of %0d link words arrived", rx_count, target);
            fail_count++;
        end
    endtask

    // link idle for quiet cycles in a row
    task automatic wait_quiet(input int quiet, input int limit);
        int idle;
        int cycles;
        idle = 0;
        cycles = 0;
        while (idle < quiet && cycles < limit) begin
            @(negedge clk_29_7_1M);
            cycles++;
            idle = o_link_valid ? 0 : idle + 1;
        end
        if (idle < quiet) begin
            $display("timeout: the link never went idle");
            fail_count++;
        end
    endtask

    initial begin
        seed = 32'h1b88848f;
        do_reset();

        // conversion, order and frame tagging over 40 samples
        drive_samples(40, 1'b0, 200);
        wait_rx(40, 400);
        wait_quiet(20, 200);
        check_value("rx_count", 32'(40), 32'(rx_count));
        check_value("o_drop_count", 32'(0), 32'(o_drop_count));

        // random valid gaps and the index restart after reset
        do_reset();
        drive_samples(40, 1'b1, 400);
        wait_rx(40, 400);
        wait_quiet(20, 200);
        check_value("rx_count", 32'(40), 32'(rx_count));
        check_value("o_drop_count", 32'(0), 32'(o_drop_count));

        // no credits back so 8 leave, 16 queue and 16 drop
        credit_en <= 1'b0;
        do_reset();
        drive_samples(40, 1'b0, 200);
        wait_quiet(30, 300);
        check_value("rx_count", 32'(adc_link_pkg::LINK_CREDITS), 32'(rx_count));
        check_value("o_drop_count", 32'(16), 32'(o_drop_count));
        credit_en <= 1'b1;
        wait_rx(24, 400);
        wait_quiet(30, 300);
        check_value("rx_count", 32'(24), 32'(rx_count));
        check_value("o_drop_count", 32'(16), 32'(o_drop_count));

        // dropped samples show as a gap, then a reset hits a busy link
        drive_samples(20, 1'b0, 100);
        do_reset();
        drive_samples(4, 1'b0, 50);
        wait_rx(4, 100);
        wait_quiet(20, 200);
        check_value("rx_count", 32'(4), 32'(rx_count));

        $display("errors: %0d value mismatches, %0d other failures", err_count, fail_count);
        if (err_count == 0 && fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/adc_capture.sv
`timescale 1ns/1ps
`default_nettype none

module adc_capture (
    input  wire                         clk_29_7_1M,
    input  wire                         rst,
    input  wire                         i_adc_valid,
    input  adc_link_pkg::adc_code_t     i_adc_a,
    input  adc_link_pkg::adc_code_t     i_adc_b,
    output logic                        o_valid,
    output adc_link_pkg::sample_pair_t  o_pair
);

    localparam int MSB = adc_link_pkg::ADC_W - 1;

    adc_link_pkg::adc_sample_t conv_a;
    adc_link_pkg::adc_sample_t conv_b;

    // offset-binary to two's complement, flip the sign bit
    assign conv_a = {~i_adc_a[MSB], i_adc_a[MSB-1:0]};
    assign conv_b = {~i_adc_b[MSB], i_adc_b[MSB-1:0]};

    always_ff @(posedge clk_29_7_1M) begin
        if (!rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_adc_valid;
        end
    end

    // payload taken every clock, o_valid qualifies it
    always_ff @(posedge clk_29_7_1M) begin
        o_pair.ch_a <= conv_a;
        o_pair.ch_b <= conv_b;
    end

endmodule

`default_nettype wire

// File: verilog/adc_fiber_link_top.sv
`timescale 1ns/1ps
`default_nettype none

module adc_fiber_link_top (
    input  wire                         clk_29_7_1M,
    input  wire                         rst,
    input  wire                         i_adc_valid,
    input  adc_link_pkg::adc_code_t     i_adc_a,
    input  adc_link_pkg::adc_code_t     i_adc_b,
    input  wire                         i_credit_return,
    output logic                        o_link_valid,
    output adc_link_pkg::link_word_t    o_link_word,
    output adc_link_pkg::drop_cnt_t     o_drop_count
);

    logic                       cap_valid;  // stage 1 out
    adc_link_pkg::sample_pair_t cap_pair;
    logic                       tag_valid;  // stage 2 out
    adc_link_pkg::link_word_t   tag_word;

    adc_capture adc_capture_inst (
        .clk_29_7_1M (clk_29_7_1M),
        .rst         (rst),
        .i_adc_valid (i_adc_valid),
        .i_adc_a     (i_adc_a),
        .i_adc_b     (i_adc_b),
        .o_valid     (cap_valid),
        .o_pair      (cap_pair)
    );

    frame_tagger frame_tagger_inst (
        .clk_29_7_1M (clk_29_7_1M),
        .rst         (rst),
        .i_valid     (cap_valid),
        .i_pair      (cap_pair),
        .o_valid     (tag_valid),
        .o_word      (tag_word)
    );

    link_credit_fifo link_credit_fifo_inst (
        .clk_29_7_1M     (clk_29_7_1M),
        .rst             (rst),
        .i_valid         (tag_valid),
        .i_word          (tag_word),
        .i_credit_return (i_credit_return),
        .o_link_valid    (o_link_valid),
        .o_link_word     (o_link_word),
        .o_drop_count    (o_drop_count)
    );

endmodule

`default_nettype wire

// File: verilog/adc_link_pkg.sv
`default_nettype none

package adc_link_pkg;

    localparam int ADC_W        = 12;  // bits per adc channel
    localparam int FRAME_LEN    = 16;  // samples per frame
    localparam int FIFO_DEPTH   = 16;
    localparam int FIFO_AW      = 4;
    localparam int LINK_CREDITS = 8;   // granted by the receiver after reset

    typedef logic [ADC_W-1:0] adc_code_t;    // raw offset-binary code
    typedef logic [ADC_W-1:0] adc_sample_t;  // two's complement
    typedef logic [3:0]       frame_idx_t;   // position within a frame
    typedef logic [3:0]       frame_num_t;   // wraps at 16
    typedef logic [3:0]       credit_cnt_t;  // 0 to LINK_CREDITS
    typedef logic [15:0]      drop_cnt_t;

    // one registered sample pair
    typedef struct packed {
        adc_sample_t ch_b;
        adc_sample_t ch_a;
    } sample_pair_t;

    // word sent on the fiber link, 32 bits
    typedef struct packed {
        adc_sample_t ch_b;
        adc_sample_t ch_a;
        frame_num_t  frame_num;
        frame_idx_t  frame_idx;
    } link_word_t;

endpackage

`default_nettype wire

// File: verilog/frame_tagger.sv
`timescale 1ns/1ps
`default_nettype none

module frame_tagger (
    input  wire                         clk_29_7_1M,
    input  wire                         rst,
    input  wire                         i_valid,
    input  adc_link_pkg::sample_pair_t  i_pair,
    output logic                        o_valid,
    output adc_link_pkg::link_word_t    o_word
);

    localparam adc_link_pkg::frame_idx_t IDX_LAST =
        adc_link_pkg::frame_idx_t'(adc_link_pkg::FRAME_LEN - 1);

    adc_link_pkg::frame_idx_t frame_idx;
    adc_link_pkg::frame_num_t frame_num;

    // counters move only on valid pairs
    always_ff @(posedge clk_29_7_1M) begin
        if (!rst) begin
            frame_idx <= '0;
            frame_num <= '0;
            o_valid   <= 1'b0;
        end else begin
            o_valid <= i_valid;
            if (i_valid) begin
                if (frame_idx == IDX_LAST) begin
                    frame_idx <= '0;
                    frame_num <= frame_num + 1'b1;  // next frame
                end else begin
                    frame_idx <= frame_idx + 1'b1;
                end
            end
        end
    end

    // tag with the counter values before they advance
    always_ff @(posedge clk_29_7_1M) begin
        if (i_valid) begin
            o_word.ch_b      <= i_pair.ch_b;
            o_word.ch_a      <= i_pair.ch_a;
            o_word.frame_num <= frame_num;
            o_word.frame_idx <= frame_idx;
        end
    end

endmodule

`default_nettype wire

// File: verilog/link_credit_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module link_credit_fifo (
    input  wire                         clk_29_7_1M,
    input  wire                         rst,
    input  wire                         i_valid,
    input  adc_link_pkg::link_word_t    i_word,
    input  wire                         i_credit_return,
    output logic                        o_link_valid,
    output adc_link_pkg::link_word_t    o_link_word,
    output adc_link_pkg::drop_cnt_t     o_drop_count
);

    localparam int AW = adc_link_pkg::FIFO_AW;
    localparam logic [AW:0] DEPTH = (AW + 1)'(adc_link_pkg::FIFO_DEPTH);
    localparam adc_link_pkg::credit_cnt_t CREDITS_INIT =
        adc_link_pkg::credit_cnt_t'(adc_link_pkg::LINK_CREDITS);

    adc_link_pkg::link_word_t mem [adc_link_pkg::FIFO_DEPTH];

    logic [AW-1:0]             wr_ptr;
    logic [AW-1:0]             rd_ptr;
    logic [AW:0]               count;     // occupancy, 0 to FIFO_DEPTH
    adc_link_pkg::credit_cnt_t credits;

    logic full;
    logic empty;
    logic wr_en;
    logic rd_en;

    assign full  = (count == DEPTH);
    assign empty = (count == '0);
    assign wr_en = i_valid && !full;
    assign rd_en = !empty && (credits != '0);  // send only with a credit in hand

    // pointers and occupancy
    always_ff @(posedge clk_29_7_1M) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk_29_7_1M) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_word;
        end
    end

    // a credit is spent with the edge that raises o_link_valid
    always_ff @(posedge clk_29_7_1M) begin
        if (!rst) begin
            credits <= CREDITS_INIT;
        end else begin
            case ({rd_en, i_credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;  // send and return cancel
            endcase
        end
    end

    always_ff @(posedge clk_29_7_1M) begin
        if (!rst) begin
            o_link_valid <= 1'b0;
        end else begin
            o_link_valid <= rd_en;
        end
    end

    always_ff @(posedge clk_29_7_1M) begin
        if (rd_en) begin
            o_link_word <= mem[rd_ptr];
        end
    end

    // words lost on a full FIFO, holds at all ones
    always_ff @(posedge clk_29_7_1M) begin
        if (!rst) begin
            o_drop_count <= '0;
        end else if (i_valid && full && (o_drop_count != '1)) begin
            o_drop_count <= o_drop_count + 1'b1;
        end
    end

endmodule

`default_nettype wire
